/* argmax_tree/argmax_tree.sv */
`timescale 1ns/1ps

module argmax_tree #(
    parameter int N_CLASS = fc_pkg::N_CLASS_DEF
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  score_valid,
    input  logic [N_CLASS-1:0][fc_pkg::ACC_W-1:0] scores,
    output logic                                  score_ready,
    output logic                                  res_valid,
    output fc_pkg::result_t                       res_data,
    input  logic                                  res_ready
);

    localparam int DEPTH = $clog2(N_CLASS);
    localparam int IDX_W = fc_pkg::IDX_W;

    // entries left after s rounds of pairing
    function automatic int stage_cnt(input int s);
        return (N_CLASS + (1 << s) - 1) >> s;
    endfunction

    logic [N_CLASS-1:0][fc_pkg::ACC_W-1:0] val [DEPTH+1];
    logic [N_CLASS-1:0][IDX_W-1:0]         cls [DEPTH+1];
    logic                                  vld [DEPTH+1];
    logic [DEPTH+1:1]                      rdy;

    assign val[0] = scores;
    assign vld[0] = score_valid;

    always_comb begin
        for (int i = 0; i < N_CLASS; i++) begin
            cls[0][i] = IDX_W'(i);
        end
    end

    // a stage moves when it is empty or the next one moves
    always_comb begin
        rdy[DEPTH+1] = res_ready;
        for (int s = DEPTH; s >= 1; s--) begin
            rdy[s] = !vld[s] || rdy[s+1];
        end
    end

    for (genvar s = 1; s <= DEPTH; s++) begin : g_stage
        localparam int N_IN  = stage_cnt(s - 1);
        localparam int N_OUT = stage_cnt(s);

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                vld[s] <= 1'b0;
            end else if (rdy[s]) begin
                vld[s] <= vld[s-1];
            end
        end

        // left keeps the slot only when strictly greater, odd leftover passes
        always_ff @(posedge clk) begin
            if (rdy[s] && vld[s-1]) begin
                for (int i = 0; i < N_OUT; i++) begin
                    if (2 * i + 1 < N_IN &&
                        $signed(val[s-1][2*i+1]) >= $signed(val[s-1][2*i])) begin
                        val[s][i] <= val[s-1][2*i+1];
                        cls[s][i] <= cls[s-1][2*i+1];
                    end else begin
                        val[s][i] <= val[s-1][2*i];
                        cls[s][i] <= cls[s-1][2*i];
                    end
                end
            end
        end
    end

    assign score_ready    = rdy[1];
    assign res_valid      = vld[DEPTH];
    assign res_data.idx   = cls[DEPTH][0];
    assign res_data.score = val[DEPTH][0];

endmodule

/* common/fc_pkg.sv */
package fc_pkg;

    // datapath widths
    localparam int DATA_W = 16;
    localparam int ACC_W  = 40;
    localparam int IDX_W  = 4;

    // default layer shape
    localparam int N_FEAT_DEF  = 16;
    localparam int N_CLASS_DEF = 10;

    // one feature value on the input stream
    typedef struct packed {
        logic signed [DATA_W-1:0] value;
    } feat_t;

    // one weight value, streamed class by class
    typedef struct packed {
        logic signed [DATA_W-1:0] value;
    } wt_t;

    // winning class and its score
    typedef struct packed {
        logic [IDX_W-1:0]        idx;
        logic signed [ACC_W-1:0] score;
    } result_t;

endpackage

/* fc_classifier.f */
common/fc_pkg.sv
rtl/stream_slice.sv
rtl/weight_store.sv
rtl/feature_buffer.sv
neuron_array/neuron_array.sv
argmax_tree/argmax_tree.sv
rtl/fc_classifier.sv
sim/tb_fc_classifier.sv

/* neuron_array/neuron_array.sv */
`timescale 1ns/1ps

module neuron_array #(
    parameter int N_FEAT  = fc_pkg::N_FEAT_DEF,
    parameter int N_CLASS = fc_pkg::N_CLASS_DEF
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   wt_loaded,
    input  logic                                   feat_full,
    output logic                                   feat_release,
    output logic [$clog2(N_FEAT)-1:0]              rd_idx,
    input  fc_pkg::wt_t [N_CLASS-1:0]              wt_row,
    input  logic signed [fc_pkg::DATA_W-1:0]       feat_out,
    output logic                                   score_valid,
    output logic [N_CLASS-1:0][fc_pkg::ACC_W-1:0]  scores,
    input  logic                                   score_ready
);

    localparam int IW = $clog2(N_FEAT);

    logic          busy;
    logic          issue;
    logic          mac_en;
    logic          mac_last;
    logic          start;
    logic          last_idx;
    logic [IW-1:0] idx;

    assign start        = feat_full && wt_loaded && !busy;
    assign last_idx     = issue && (idx == IW'(N_FEAT - 1));
    assign feat_release = last_idx;
    assign rd_idx       = idx;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy        <= 1'b0;
            issue       <= 1'b0;
            idx         <= '0;
            mac_en      <= 1'b0;
            mac_last    <= 1'b0;
            score_valid <= 1'b0;
        end else begin
            // store and buffer answer one cycle after the index
            mac_en   <= issue;
            mac_last <= last_idx;

            if (start) begin
                busy  <= 1'b1;
                issue <= 1'b1;
                idx   <= '0;
            end else if (last_idx) begin
                issue <= 1'b0;
                idx   <= '0;
            end else if (issue) begin
                idx <= idx + 1'b1;
            end

            if (mac_last) begin
                score_valid <= 1'b1;
            end else if (score_valid && score_ready) begin
                score_valid <= 1'b0;
                busy        <= 1'b0;
            end
        end
    end

    // all classes share the same feature each cycle
    always_ff @(posedge clk) begin
        if (start) begin
            scores <= '0;
        end else if (mac_en) begin
            for (int c = 0; c < N_CLASS; c++) begin
                scores[c] <= $signed(scores[c]) + $signed(wt_row[c].value) * feat_out;
            end
        end
    end

    idx_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        issue |-> int'(rd_idx) < N_FEAT
    );

    score_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        start |-> ##(N_FEAT + 2) score_valid
    );

endmodule

/* rtl/fc_classifier.sv */
`timescale 1ns/1ps

module fc_classifier #(
    parameter int N_FEAT  = fc_pkg::N_FEAT_DEF,
    parameter int N_CLASS = fc_pkg::N_CLASS_DEF
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            wt_valid,
    input  fc_pkg::wt_t     wt_data,
    output logic            wt_ready,
    input  logic            feat_valid,
    input  fc_pkg::feat_t   feat_data,
    output logic            feat_ready,
    output logic            res_valid,
    output fc_pkg::result_t res_data,
    input  logic            res_ready
);

    logic                                  wt_in_valid;
    logic                                  wt_in_ready;
    logic                                  wt_s_valid;
    fc_pkg::wt_t                           wt_s_data;
    logic                                  wt_s_ready;
    logic                                  feat_s_valid;
    fc_pkg::feat_t                         feat_s_data;
    logic                                  feat_s_ready;
    logic [$clog2(N_FEAT)-1:0]             rd_idx;
    fc_pkg::wt_t [N_CLASS-1:0]             wt_row;
    logic signed [fc_pkg::DATA_W-1:0]      feat_out;
    logic                                  wt_loaded;
    logic                                  feat_full;
    logic                                  feat_release;
    logic                                  score_valid;
    logic [N_CLASS-1:0][fc_pkg::ACC_W-1:0] scores;
    logic                                  score_ready;
    logic                                  tree_valid;
    fc_pkg::result_t                       tree_data;
    logic                                  tree_ready;

    // weight input closes for good once the store is loaded
    assign wt_ready    = wt_in_ready && wt_s_ready;
    assign wt_in_valid = wt_valid && wt_s_ready;

    stream_slice #(.payload_t(fc_pkg::wt_t)) u_wt_slice (
        .clk(clk), .rstn(rstn),
        .in_valid(wt_in_valid), .in_data(wt_data), .in_ready(wt_in_ready),
        .out_valid(wt_s_valid), .out_data(wt_s_data), .out_ready(wt_s_ready)
    );

    stream_slice #(.payload_t(fc_pkg::feat_t)) u_feat_slice (
        .clk(clk), .rstn(rstn),
        .in_valid(feat_valid), .in_data(feat_data), .in_ready(feat_ready),
        .out_valid(feat_s_valid), .out_data(feat_s_data), .out_ready(feat_s_ready)
    );

    weight_store #(.N_FEAT(N_FEAT), .N_CLASS(N_CLASS)) u_weight_store (
        .clk(clk), .rstn(rstn),
        .wt_valid(wt_s_valid), .wt_data(wt_s_data), .wt_ready(wt_s_ready),
        .rd_idx(rd_idx), .wt_row(wt_row), .wt_loaded(wt_loaded)
    );

    feature_buffer #(.N_FEAT(N_FEAT)) u_feature_buffer (
        .clk(clk), .rstn(rstn),
        .feat_valid(feat_s_valid), .feat_data(feat_s_data), .feat_ready(feat_s_ready),
        .rd_idx(rd_idx), .feat_out(feat_out),
        .feat_full(feat_full), .feat_release(feat_release)
    );

    neuron_array #(.N_FEAT(N_FEAT), .N_CLASS(N_CLASS)) u_neuron_array (
        .clk(clk), .rstn(rstn),
        .wt_loaded(wt_loaded), .feat_full(feat_full), .feat_release(feat_release),
        .rd_idx(rd_idx), .wt_row(wt_row), .feat_out(feat_out),
        .score_valid(score_valid), .scores(scores), .score_ready(score_ready)
    );

    argmax_tree #(.N_CLASS(N_CLASS)) u_argmax_tree (
        .clk(clk), .rstn(rstn),
        .score_valid(score_valid), .scores(scores), .score_ready(score_ready),
        .res_valid(tree_valid), .res_data(tree_data), .res_ready(tree_ready)
    );

    stream_slice #(.payload_t(fc_pkg::result_t)) u_res_slice (
        .clk(clk), .rstn(rstn),
        .in_valid(tree_valid), .in_data(tree_data), .in_ready(tree_ready),
        .out_valid(res_valid), .out_data(res_data), .out_ready(res_ready)
    );

endmodule

/* rtl/feature_buffer.sv */
`timescale 1ns/1ps

module feature_buffer #(
    parameter int N_FEAT = fc_pkg::N_FEAT_DEF
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             feat_valid,
    input  fc_pkg::feat_t                    feat_data,
    output logic                             feat_ready,
    input  logic [$clog2(N_FEAT)-1:0]        rd_idx,
    output logic signed [fc_pkg::DATA_W-1:0] feat_out,
    output logic                             feat_full,
    input  logic                             feat_release
);

    localparam int IW = $clog2(N_FEAT);

    fc_pkg::feat_t entry [N_FEAT];

    logic [IW-1:0] wr_idx;
    logic          take;

    assign feat_ready = !feat_full;
    assign take       = feat_valid && feat_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_idx    <= '0;
            feat_full <= 1'b0;
        end else if (feat_release) begin
            feat_full <= 1'b0;
        end else if (take) begin
            if (wr_idx == IW'(N_FEAT - 1)) begin
                wr_idx    <= '0;
                feat_full <= 1'b1;
            end else begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // writes fill in arrival order, reads take one cycle
    always_ff @(posedge clk) begin
        if (take) begin
            entry[wr_idx] <= feat_data;
        end
        feat_out <= entry[rd_idx].value;
    end

    release_when_full: assert property (
        @(posedge clk) disable iff (!rstn)
        feat_release |-> feat_full
    );

endmodule

/* rtl/stream_slice.sv */
`timescale 1ns/1ps

module stream_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     full;
    payload_t data_q;

    // accept when empty or when the held word leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    hold_under_stall: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

/* rtl/weight_store.sv */
`timescale 1ns/1ps

module weight_store #(
    parameter int N_FEAT  = fc_pkg::N_FEAT_DEF,
    parameter int N_CLASS = fc_pkg::N_CLASS_DEF
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      wt_valid,
    input  fc_pkg::wt_t               wt_data,
    output logic                      wt_ready,
    input  logic [$clog2(N_FEAT)-1:0] rd_idx,
    output fc_pkg::wt_t [N_CLASS-1:0] wt_row,
    output logic                      wt_loaded
);

    localparam int IW = $clog2(N_FEAT);
    localparam int CW = (N_CLASS > 1) ? $clog2(N_CLASS) : 1;

    // one row per feature index, one column per class
    fc_pkg::wt_t [N_CLASS-1:0] mem [N_FEAT];

    logic [IW-1:0] feat_cnt;
    logic [CW-1:0] class_cnt;
    logic          take;

    assign wt_ready = !wt_loaded;
    assign take     = wt_valid && wt_ready;

    // words come class-major, feature index runs fastest
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            feat_cnt  <= '0;
            class_cnt <= '0;
            wt_loaded <= 1'b0;
        end else if (take) begin
            if (feat_cnt == IW'(N_FEAT - 1)) begin
                feat_cnt <= '0;
                if (class_cnt == CW'(N_CLASS - 1)) begin
                    wt_loaded <= 1'b1;
                end else begin
                    class_cnt <= class_cnt + 1'b1;
                end
            end else begin
                feat_cnt <= feat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem[feat_cnt][class_cnt] <= wt_data;
        end
        wt_row <= mem[rd_idx];
    end

    // no further word may reach the store once the full set is in
    load_once: assert property (
        @(posedge clk) disable iff (!rstn)
        wt_loaded |-> !wt_valid
    );

endmodule

/* sim/tb_fc_classifier.sv */
`timescale 1ns/1ps

module tb_fc_classifier;

    localparam int N_FEAT  = fc_pkg::N_FEAT_DEF;
    localparam int N_CLASS = fc_pkg::N_CLASS_DEF;
    localparam int DATA_W  = fc_pkg::DATA_W;
    localparam int ACC_W   = fc_pkg::ACC_W;
    localparam int IDX_W   = fc_pkg::IDX_W;

    localparam int N_WORDS  = N_CLASS * N_FEAT;
    localparam int N_IMAGES = 1 + 4 + 20 + 10;
    localparam int TIMEOUT_CYCLES = 4 * (N_WORDS + N_IMAGES * (2 * N_FEAT + 20)) + 200;
    localparam int DRAIN_LIMIT = 400;

    localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};
    localparam logic [DATA_W-1:0] MOST_POS = {1'b0, {(DATA_W-1){1'b1}}};

    typedef logic [N_FEAT-1:0][DATA_W-1:0] image_t;

    logic            clk;
    logic            rstn;
    logic            wt_valid;
    fc_pkg::wt_t     wt_data;
    logic            wt_ready;
    logic            feat_valid;
    fc_pkg::feat_t   feat_data;
    logic            feat_ready;
    logic            res_valid;
    fc_pkg::result_t res_data;
    logic            res_ready;

    integer seed;
    logic [31:0] rnd_bp;
    logic bp_mode;
    logic wt_done;
    int err_count;
    int pass_tests;
    int fail_tests;
    int results_seen;
    int wt_reopen;
    int cycles;
    logic hold_pending;
    fc_pkg::result_t hold_data;
    fc_pkg::result_t want;
    fc_pkg::result_t exp_q [$];

    // weights kept by class, then feature
    logic [N_CLASS-1:0][N_FEAT-1:0][DATA_W-1:0] wts;

    fc_classifier #(.N_FEAT(N_FEAT), .N_CLASS(N_CLASS)) UUT (
        .clk(clk), .rstn(rstn),
        .wt_valid(wt_valid), .wt_data(wt_data), .wt_ready(wt_ready),
        .feat_valid(feat_valid), .feat_data(feat_data), .feat_ready(feat_ready),
        .res_valid(res_valid), .res_data(res_data), .res_ready(res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sum of products per class, highest index wins a tie
    function automatic fc_pkg::result_t ref_classify(input image_t img);
        fc_pkg::result_t best;
        longint acc;
        longint best_acc;
        best_acc = 0;
        best.idx = '0;
        best.score = '0;
        for (int c = 0; c < N_CLASS; c++) begin
            acc = 0;
            for (int f = 0; f < N_FEAT; f++) begin
                acc += longint'($signed(wts[c][f])) * longint'($signed(img[f]));
            end
            if (c == 0 || acc >= best_acc) begin
                best_acc = acc;
                best.idx = IDX_W'(c);
                best.score = ACC_W'(acc);
            end
        end
        return best;
    endfunction

    function automatic image_t random_image();
        image_t img;
        logic [31:0] r;
        for (int f = 0; f < N_FEAT; f++) begin
            r = $random(seed);
            img[f] = r[DATA_W-1:0];
        end
        return img;
    endfunction

    // callers enter 1 ns after a rising edge; ready never depends on valid
    task automatic push_weight(input logic [DATA_W-1:0] w);
        logic taken;
        wt_valid = 1'b1;
        wt_data.value = w;
        taken = 1'b0;
        while (!taken) begin
            taken = wt_ready;
            @(posedge clk);
            #1;
        end
        wt_valid = 1'b0;
    endtask

    task automatic push_feature(input logic [DATA_W-1:0] v);
        logic taken;
        feat_valid = 1'b1;
        feat_data.value = v;
        taken = 1'b0;
        while (!taken) begin
            taken = feat_ready;
            @(posedge clk);
            #1;
        end
        feat_valid = 1'b0;
    endtask

    task automatic load_weights();
        logic [31:0] r;
        logic [DATA_W-1:0] w;
        for (int c = 0; c < N_CLASS; c++) begin
            for (int f = 0; f < N_FEAT; f++) begin
                r = $random(seed);
                w = r[DATA_W-1:0];
                // planted ties: classes 0 and last on the last feature, 2 and 6 on the one before
                if (f == N_FEAT - 1) begin
                    if (c == 0 || c == N_CLASS - 1) w = MOST_NEG;
                    else if (w == MOST_NEG) w = MOST_NEG + 1'b1;
                end else if (f == N_FEAT - 2) begin
                    if (c == 2 || c == 6) w = MOST_POS;
                    else if (w == MOST_POS) w = MOST_POS - 1'b1;
                end
                wts[c][f] = w;
            end
        end
        for (int c = 0; c < N_CLASS; c++) begin
            for (int f = 0; f < N_FEAT; f++) begin
                push_weight(wts[c][f]);
            end
        end
        // last word still passes the input slice
        repeat (2) @(posedge clk);
        #1;
        wt_done = 1'b1;
    endtask

    task automatic send_image(input image_t img);
        exp_q.push_back(ref_classify(img));
        for (int f = 0; f < N_FEAT; f++) begin
            push_feature(img[f]);
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d results never arrived by %0t", exp_q.size(), $time);
            exp_q.delete();
        end
    endtask

    task automatic check_idle(input string when);
        if (res_valid !== 1'b0) begin
            err_count++;
            $display("res_valid is not low %s at %0t", when, $time);
        end
        if (feat_ready !== 1'b1) begin
            err_count++;
            $display("feat_ready is not high %s at %0t", when, $time);
        end
        if (wt_ready !== 1'b1) begin
            err_count++;
            $display("wt_ready is not high %s at %0t", when, $time);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: passed", name);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // random back-pressure on the result stream
    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            rnd_bp = $random(seed);
            res_ready = rnd_bp[0];
        end else begin
            res_ready = 1'b1;
        end
    end

    // nothing changes between the falling edge and the next rising edge
    always @(negedge clk) begin
        if (res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("a result arrived at %0t with no image pending", $time);
            end else begin
                want = exp_q.pop_front();
                results_seen++;
                if (res_data.idx !== want.idx) begin
                    err_count++;
                    $display("mismatch at %0t: res_data.idx expected %0d got %0d",
                             $time, want.idx, res_data.idx);
                end
                if (res_data.score !== want.score) begin
                    err_count++;
                    $display("mismatch at %0t: res_data.score expected %0d got %0d",
                             $time, want.score, res_data.score);
                end
            end
        end
        if (hold_pending) begin
            if (!res_valid) begin
                err_count++;
                $display("res_valid dropped at %0t before its result was taken", $time);
            end else if (res_data !== hold_data) begin
                err_count++;
                $display("mismatch at %0t: res_data while waiting expected %h got %h",
                         $time, hold_data, res_data);
            end
        end
        hold_pending = res_valid && !res_ready;
        hold_data = res_data;
        if (wt_done && wt_ready) begin
            if (wt_reopen == 0) begin
                err_count++;
                $display("wt_ready went high again after the weight load at %0t", $time);
            end
            wt_reopen++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main_seq
        image_t img;
        image_t bp_imgs [10];
        int errs_before;
        seed = 85;
        rstn = 1'b0;
        wt_valid = 1'b0;
        wt_data = '0;
        feat_valid = 1'b0;
        feat_data = '0;
        res_ready = 1'b1;
        bp_mode = 1'b0;
        wt_done = 1'b0;
        hold_pending = 1'b0;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        results_seen = 0;
        wt_reopen = 0;

        errs_before = err_count;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        @(posedge clk);
        #1;
        end_test("reset", errs_before);

        errs_before = err_count;
        load_weights();
        img = random_image();
        send_image(img);
        wait_results();
        end_test("weight load and single image", errs_before);

        // all zero ties every class, the rest hit the planted ties
        errs_before = err_count;
        img = '0;
        send_image(img);
        img[N_FEAT-1] = MOST_NEG;
        send_image(img);
        img = '0;
        img[N_FEAT-2] = MOST_POS;
        send_image(img);
        img = {N_FEAT{MOST_NEG}};
        send_image(img);
        wait_results();
        end_test("ties and extremes", errs_before);

        errs_before = err_count;
        for (int n = 0; n < 20; n++) begin
            img = random_image();
            send_image(img);
        end
        wait_results();
        end_test("back-to-back images", errs_before);

        errs_before = err_count;
        for (int n = 0; n < 10; n++) begin
            bp_imgs[n] = random_image();
        end
        bp_mode = 1'b1;
        for (int n = 0; n < 10; n++) begin
            send_image(bp_imgs[n]);
        end
        wait_results();
        bp_mode = 1'b0;
        end_test("result back-pressure", errs_before);

        errs_before = err_count;
        @(negedge clk);
        if (wt_ready !== 1'b0) begin
            err_count++;
            $display("wt_ready is high at %0t after the weights were loaded", $time);
        end
        if (wt_reopen != 0) begin
            err_count++;
            $display("wt_ready reopened on %0d cycles during the run", wt_reopen);
        end
        @(posedge clk);
        #1;
        end_test("weights accepted once", errs_before);

        $display("tests passed: %0d, tests failed: %0d, results checked: %0d",
                 pass_tests, fail_tests, results_seen);
        if (fail_tests == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
